// File: hdl/fifo_wr_if.sv
`timescale 1ns/1ps

// write side of a FIFO, payload type set per instance
interface fifo_wr_if #(
	parameter type T = logic
) ();

	logic wr_en;     // store strobe, ignored while full
	T     wr_data;
	logic full;      // level at depth
	logic prog_full; // level at or over the programmed mark

	// producer side
	modport writer (
		output wr_en,
		output wr_data,
		input  full,
		input  prog_full
	);

	// storage side
	modport fifo (
		input  wr_en,
		input  wr_data,
		output full,
		output prog_full
	);

endinterface

// File: hdl/imager_pkg.sv
package imager_pkg;

	////////////////////////////////////////
	// pixel path
	////////////////////////////////////////

	localparam int ADC_W           = 8;  // one ADC sample
	localparam int BYTES_PER_PIXEL = 3;  // ADC bytes per pixel word

	// first byte lands in the low bits
	typedef logic [BYTES_PER_PIXEL*ADC_W-1:0] pixel_word_t;

	////////////////////////////////////////
	// pattern path
	////////////////////////////////////////

	localparam int MEM_W           = 64; // pattern memory word
	localparam int SLICE_W         = 16; // one slice of a memory word
	localparam int SLICES_PER_WORD = MEM_W / SLICE_W;
	localparam int PAT_LSB         = 6;  // bits below this are not part of the mask

	// slice bits SLICE_W-1 .. PAT_LSB, 10 bits of mask per sensor row group
	typedef logic [SLICE_W-PAT_LSB-1:0] pattern_t;

	typedef logic [MEM_W-1:0] mem_word_t;

endpackage

// File: hdl/imager_top.sv
`timescale 1ns/1ps

// on-chip data movement of the coded-exposure imager
// pixel path: ADC bytes -> packer -> output buffer -> host
// pattern path: memory words -> unpacker -> pattern queue -> sensor
module imager_top
	import imager_pkg::*;
#(
	parameter int FRAME_WORDS  = 8,  // pixel words per frame
	parameter int PIX_DEPTH    = 32, // output buffer depth
	parameter int PAT_DEPTH    = 8,  // pattern queue depth
	parameter int PAT_LOW_MARK = 2   // pattern queue low level
) (
	input  logic             CLK_HS,
	input  logic             arst_n,

	// pixel side
	input  logic [ADC_W-1:0] im_data,
	input  logic             im_data_val,
	input  logic             host_rd,     // pop from output buffer
	output pixel_word_t      pixel_data,
	output logic             pixel_avail,
	output logic             pix_full,
	output logic             frame_ready, // one frame held
	output logic             two_frames,  // two frames held

	// pattern side
	input  mem_word_t        mem_word,
	input  logic             mem_valid,
	output logic             mem_ready,
	input  logic             stream,      // sensor pops one pattern
	output pattern_t         mstream,
	output logic             pat_avail,
	output logic             pat_low,     // queue running low
	input  logic             pat_flush
);

	////////////////////////////////////////
	// pixel path
	////////////////////////////////////////

	fifo_wr_if #(.T(pixel_word_t)) pix_wr ();

	pixel_packer u_pixel_packer (
		.CLK_HS      (CLK_HS),
		.arst_n      (arst_n),
		.im_data     (im_data),
		.im_data_val (im_data_val),
		.pix_wr      (pix_wr.writer)
	);

	sync_fifo #(
		.T          (pixel_word_t),
		.DEPTH      (PIX_DEPTH),
		.PROG_FULL  (2 * FRAME_WORDS), // two frames flag
		.PROG_EMPTY (1),
		.FRAME_MARK (FRAME_WORDS)
	) u_pix_fifo (
		.CLK_HS     (CLK_HS),
		.arst_n     (arst_n),
		.clear      (1'b0),       // pixel buffer only cleared by reset
		.rd         (host_rd),
		.wr         (pix_wr.fifo),
		.dout       (pixel_data),
		.avail      (pixel_avail),
		.prog_empty (),
		.frame_mark (frame_ready)
	);

	assign pix_full   = pix_wr.full;
	assign two_frames = pix_wr.prog_full;

	////////////////////////////////////////
	// pattern path
	////////////////////////////////////////

	fifo_wr_if #(.T(pattern_t)) pat_wr ();

	pattern_unpacker u_pattern_unpacker (
		.CLK_HS    (CLK_HS),
		.arst_n    (arst_n),
		.mem_word  (mem_word),
		.mem_valid (mem_valid),
		.pat_flush (pat_flush),
		.mem_ready (mem_ready),
		.pat_wr    (pat_wr.writer)
	);

	sync_fifo #(
		.T          (pattern_t),
		.DEPTH      (PAT_DEPTH),
		.PROG_FULL  (PAT_DEPTH),
		.PROG_EMPTY (PAT_LOW_MARK),
		.FRAME_MARK (1)
	) u_pat_fifo (
		.CLK_HS     (CLK_HS),
		.arst_n     (arst_n),
		.clear      (pat_flush),  // same edge as the unpacker drop
		.rd         (stream),
		.wr         (pat_wr.fifo),
		.dout       (mstream),
		.avail      (pat_avail),
		.prog_empty (pat_low),
		.frame_mark ()
	);

endmodule

// File: hdl/pattern_unpacker.sv
`timescale 1ns/1ps

// splits 64-bit pattern memory words into four slices, lowest first,
// and pushes the mask bits of each slice into the pattern queue
module pattern_unpacker
	import imager_pkg::*;
(
	input  logic      CLK_HS,
	input  logic      arst_n,
	input  mem_word_t mem_word,  // word from pattern memory
	input  logic      mem_valid,
	input  logic      pat_flush, // sync clear of the pattern path
	output logic      mem_ready, // high while no word is held
	fifo_wr_if.writer pat_wr
);

	localparam int IDX_W = $clog2(SLICES_PER_WORD);
	localparam logic [IDX_W-1:0] LAST_SLICE = IDX_W'(SLICES_PER_WORD - 1);

	mem_word_t          mem_q;     // held memory word
	logic               busy;      // mem_q holds unsent slices
	logic [IDX_W-1:0]   slice_idx; // slice currently offered
	logic [SLICE_W-1:0] cur_slice;
	logic               take;      // memory handshake
	logic               wr_fire;   // slice goes into the queue this edge

	assign mem_ready = ~busy;
	assign take      = mem_valid & mem_ready;

	////////////////////////////////////////
	// slice select and queue write
	////////////////////////////////////////

	assign cur_slice      = mem_q[slice_idx*SLICE_W +: SLICE_W];
	assign pat_wr.wr_data = cur_slice[PAT_LSB +: $bits(pattern_t)]; // drop low status bits
	assign wr_fire        = busy & ~pat_wr.full; // hold slice while queue full
	assign pat_wr.wr_en   = wr_fire;

	////////////////////////////////////////
	// word hold and slice index
	////////////////////////////////////////

	always_ff @(posedge CLK_HS or negedge arst_n) begin
		if (!arst_n) begin
			busy      <= 1'b0;
			slice_idx <= '0;
		end else if (take) begin
			busy      <= 1'b1; // first slice goes out from the next edge
			slice_idx <= '0;
		end else if (pat_flush) begin
			// held word dropped, queue is cleared on the same edge
			busy      <= 1'b0;
			slice_idx <= '0;
		end else if (wr_fire) begin
			if (slice_idx == LAST_SLICE) begin
				busy      <= 1'b0; // word done, ready again
				slice_idx <= '0;
			end else begin
				slice_idx <= slice_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK_HS) begin
		if (take)
			mem_q <= mem_word;
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// no write reaches a full queue, so back-pressure never loses a slice
	a_no_wr_full: assert property (
		@(posedge CLK_HS) disable iff (!arst_n)
		pat_wr.wr_en |-> !pat_wr.full
	);

	// a word part way through its slices is never released
	a_idx_busy: assert property (
		@(posedge CLK_HS) disable iff (!arst_n)
		(slice_idx != '0) |-> !mem_ready
	);

endmodule

// File: hdl/pixel_packer.sv
`timescale 1ns/1ps

// gathers ADC bytes into 24-bit pixel words
// no back-pressure toward the ADC, a word that meets a full buffer is lost
module pixel_packer
	import imager_pkg::*;
(
	input  logic              CLK_HS,
	input  logic              arst_n,
	input  logic [ADC_W-1:0]  im_data,     // one ADC byte
	input  logic              im_data_val, // byte strobe
	fifo_wr_if.writer         pix_wr
);

	localparam int CNT_W = $clog2(BYTES_PER_PIXEL);
	localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(BYTES_PER_PIXEL - 1);

	logic [CNT_W-1:0] byte_cnt; // lane of the next byte
	pixel_word_t      pix_reg;  // word under assembly
	logic             wr_q;     // one-cycle write strobe

	////////////////////////////////////////
	// byte counter and write strobe
	////////////////////////////////////////

	always_ff @(posedge CLK_HS or negedge arst_n) begin
		if (!arst_n) begin
			byte_cnt <= '0;
			wr_q     <= 1'b0;
		end else begin
			wr_q <= 1'b0; // default, pulse only
			if (im_data_val) begin
				if (byte_cnt == LAST_BYTE) begin
					byte_cnt <= '0;
					wr_q     <= 1'b1; // word complete, store next edge
				end else begin
					byte_cnt <= byte_cnt + 1'b1;
				end
			end
		end
	end

	// payload lanes, first byte in bits 7..0
	always_ff @(posedge CLK_HS) begin
		if (im_data_val)
			pix_reg[byte_cnt*ADC_W +: ADC_W] <= im_data;
	end

	// the buffer samples pix_reg on the edge after the third byte,
	// before a following byte can overwrite lane 0
	assign pix_wr.wr_en   = wr_q;
	assign pix_wr.wr_data = pix_reg;

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// counter wraps at the third byte
	a_cnt_range: assert property (
		@(posedge CLK_HS) disable iff (!arst_n)
		byte_cnt != CNT_W'(BYTES_PER_PIXEL)
	);

endmodule

// File: hdl/sync_fifo.sv
`timescale 1ns/1ps

// single clock FIFO, first word falls through to dout
// level flags for full, prog_full, prog_empty and a frame mark
module sync_fifo #(
	parameter type T          = logic,
	parameter int  DEPTH      = 8,
	parameter int  PROG_FULL  = DEPTH, // prog_full at or above this level
	parameter int  PROG_EMPTY = 1,     // prog_empty below this level
	parameter int  FRAME_MARK = 1      // frame_mark at or above this level
) (
	input  logic    CLK_HS,
	input  logic    arst_n,
	input  logic    clear,  // sync empty
	input  logic    rd,     // pop strobe, ignored while empty
	fifo_wr_if.fifo wr,
	output T        dout,   // head of queue
	output logic    avail,
	output logic    prog_empty,
	output logic    frame_mark
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int LVL_W = $clog2(DEPTH + 1);

	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
	localparam logic [LVL_W-1:0] LVL_FULL = LVL_W'(DEPTH);
	localparam logic [LVL_W-1:0] LVL_PF   = LVL_W'(PROG_FULL);
	localparam logic [LVL_W-1:0] LVL_PE   = LVL_W'(PROG_EMPTY);
	localparam logic [LVL_W-1:0] LVL_FM   = LVL_W'(FRAME_MARK);

	T                 mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [LVL_W-1:0] level;
	logic             wr_ok; // write accepted
	logic             rd_ok; // pop accepted

	// pointer step with wrap for any depth
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == LAST_PTR) ? '0 : p + 1'b1;
	endfunction

	assign wr_ok = wr.wr_en & ~wr.full; // full drops the word
	assign rd_ok = rd & avail;

	////////////////////////////////////////
	// pointers and level
	////////////////////////////////////////

	always_ff @(posedge CLK_HS or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else if (clear) begin
			wr_ptr <= '0; // clear beats a same-cycle write
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= ptr_next(wr_ptr);
			if (rd_ok)
				rd_ptr <= ptr_next(rd_ptr);
			case ({wr_ok, rd_ok})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level; // none, or push and pop together
			endcase
		end
	end

	// storage
	always_ff @(posedge CLK_HS) begin
		if (wr_ok)
			mem[wr_ptr] <= wr.wr_data;
	end

	////////////////////////////////////////
	// outputs and flags
	////////////////////////////////////////

	assign dout         = mem[rd_ptr];
	assign avail        = (level != '0);
	assign wr.full      = (level == LVL_FULL);
	assign wr.prog_full = (level >= LVL_PF);
	assign prog_empty   = (level < LVL_PE);
	assign frame_mark   = (level >= LVL_FM);

	// level tracks the pointers and stays within the array
	a_level_max: assert property (
		@(posedge CLK_HS) disable iff (!arst_n)
		level <= LVL_FULL
	);

endmodule

// File: imager_stream.f
hdl/imager_pkg.sv
hdl/fifo_wr_if.sv
hdl/pixel_packer.sv
hdl/pattern_unpacker.sv
hdl/sync_fifo.sv
hdl/imager_top.sv
verification/tb_clock_gen.sv
verification/imager_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the imager testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
	--top-module imager_tb \
	--Mdir "$BUILD_DIR" \
	-f imager_stream.f

"./$BUILD_DIR/Vimager_tb" | tee "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
	echo "simulation reported a failure, see $LOG"
	exit 1
fi
echo "simulation finished, log in $LOG"

// File: verification/imager_tb.sv
`timescale 1ns/1ps

// vector-driven testbench for imager_top
module imager_tb
	import imager_pkg::*;
();

	localparam int WAIT_LIMIT = 200; // cycles allowed for any handshake

	logic             CLK_HS;
	logic             arst_n;
	logic [ADC_W-1:0] im_data;
	logic             im_data_val;
	logic             host_rd;
	pixel_word_t      pixel_data;
	logic             pixel_avail;
	logic             pix_full;
	logic             frame_ready;
	logic             two_frames;
	mem_word_t        mem_word;
	logic             mem_valid;
	logic             mem_ready;
	logic             stream;
	pattern_t         mstream;
	logic             pat_avail;
	logic             pat_low;
	logic             pat_flush;

	integer          seed;      // ADC byte gaps
	int              n_tests;
	int              n_failed;
	int              n_errors;
	int              test_errs; // errors in the running test
	logic            test_open;
	logic [8*32-1:0] test_name;

	tb_clock_gen u_clk_gen (.CLK_HS(CLK_HS), .arst_n(arst_n));

	imager_top DUT (.*);

	////////////////////////////////////////
	// drivers
	////////////////////////////////////////

	task automatic next_cycle();
		@(posedge CLK_HS);
		#2; // inputs move just after the edge
	endtask

	task automatic report_fail(input string msg);
		$display("Fail at %0d ns: %s", $time, msg);
		test_errs++;
	endtask

	task automatic push_byte(input logic [ADC_W-1:0] b);
		int gap;
		im_data     = b;
		im_data_val = 1'b1;
		next_cycle();
		im_data_val = 1'b0;
		gap = $random(seed) & 3; // 0..3 idle cycles
		repeat (gap) next_cycle();
	endtask

	// pixel k of a run, bytes count up from first, first byte in the low lane
	function automatic pixel_word_t run_word(input logic [ADC_W-1:0] first, input int k);
		logic [ADC_W-1:0] b0;
		b0 = first + ADC_W'(3 * k);
		return {b0 + 8'd2, b0 + 8'd1, b0};
	endfunction

	task automatic push_pixel_run(input int n, input logic [ADC_W-1:0] first);
		pixel_word_t w;
		for (int k = 0; k < n; k++) begin
			w = run_word(first, k);
			push_byte(w[7:0]);
			push_byte(w[15:8]);
			push_byte(w[23:16]);
		end
	endtask

	task automatic read_pixel(input pixel_word_t exp);
		int t;
		t = 0;
		while (!pixel_avail && t < WAIT_LIMIT) begin
			next_cycle();
			t++;
		end
		if (!pixel_avail) begin
			$display("timeout at %0d ns, no pixel word showed up", $time);
			test_errs++;
		end else begin
			if (pixel_data !== exp)
				report_fail($sformatf("pixel_data %h, expected %h", pixel_data, exp));
			host_rd = 1'b1; // pop the head
			next_cycle();
			host_rd = 1'b0;
		end
	endtask

	task automatic read_pixel_run(input int n, input logic [ADC_W-1:0] first);
		for (int k = 0; k < n; k++)
			read_pixel(run_word(first, k));
	endtask

	task automatic push_mem_word(input mem_word_t w);
		int t;
		t = 0;
		while (!mem_ready && t < WAIT_LIMIT) begin
			next_cycle();
			t++;
		end
		if (!mem_ready) begin
			$display("timeout at %0d ns, mem_ready stayed low", $time);
			test_errs++;
		end else begin
			mem_word  = w;
			mem_valid = 1'b1; // taken on the next edge
			next_cycle();
			mem_valid = 1'b0;
		end
	endtask

	task automatic stream_pattern(input pattern_t exp);
		int t;
		t = 0;
		while (!pat_avail && t < WAIT_LIMIT) begin
			next_cycle();
			t++;
		end
		if (!pat_avail) begin
			$display("timeout at %0d ns, no pattern in the queue", $time);
			test_errs++;
		end else begin
			if (mstream !== exp)
				report_fail($sformatf("mstream %h, expected %h", mstream, exp));
			stream = 1'b1;
			next_cycle();
			stream = 1'b0;
		end
	endtask

	task automatic flush_patterns();
		pat_flush = 1'b1;
		next_cycle();
		pat_flush = 1'b0;
	endtask

	// order: pixel_avail pix_full frame_ready two_frames pat_avail mem_ready pat_low
	task automatic check_flags(input logic [6:0] exp);
		logic [6:0] got;
		repeat (2) next_cycle(); // a pending buffer write lands first
		got = {pixel_avail, pix_full, frame_ready, two_frames, pat_avail, mem_ready, pat_low};
		if (got !== exp)
			report_fail($sformatf("flags %b, expected %b", got, exp));
	endtask

	task automatic close_test();
		if (test_open) begin
			if (test_errs == 0) begin
				$display("test %0s: ok", test_name);
			end else begin
				$display("test %0s: %0d errors", test_name, test_errs);
				n_failed++;
			end
		end
		n_errors += test_errs;
	endtask

	////////////////////////////////////////
	// vector loop
	////////////////////////////////////////

	initial begin
		int          fd;
		int          t;
		string       line;
		logic [7:0]  cmd;
		logic [63:0] a0;
		logic [63:0] a1;
		logic [63:0] a2;
		seed        = 32'hbbd18da1;
		im_data     = '0;
		im_data_val = 1'b0;
		host_rd     = 1'b0;
		mem_word    = '0;
		mem_valid   = 1'b0;
		stream      = 1'b0;
		pat_flush   = 1'b0;
		n_tests     = 0;
		n_failed    = 0;
		n_errors    = 0;
		test_errs   = 0;
		test_open   = 1'b0;
		fd = $fopen("verification/imager_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open verification/imager_vectors.txt");
			n_errors++;
		end else begin
			t = 0;
			while (!arst_n && t < WAIT_LIMIT) begin
				@(posedge CLK_HS);
				t++;
			end
			if (!arst_n) begin
				$display("reset never released");
				n_errors++;
			end
			next_cycle();
			while ($fgets(line, fd) > 0) begin
				cmd = "#";
				a0  = '0;
				a1  = '0;
				a2  = '0;
				void'($sscanf(line, "%c %h %h %h", cmd, a0, a1, a2));
				case (cmd)
					"T": begin
						close_test(); // previous test reports here
						void'($sscanf(line, "%c %s", cmd, test_name));
						test_open = 1'b1;
						test_errs = 0;
						n_tests++;
					end
					"W": begin
						push_byte(a0[ADC_W-1:0]);
						push_byte(a1[ADC_W-1:0]);
						push_byte(a2[ADC_W-1:0]);
					end
					"B": push_pixel_run(int'(a0), a1[ADC_W-1:0]);
					"R": read_pixel(a0[23:0]);
					"Q": read_pixel_run(int'(a0), a1[ADC_W-1:0]);
					"F": check_flags(a0[6:0]);
					"M": push_mem_word(a0);
					"S": stream_pattern(a0[9:0]);
					"X": flush_patterns();
					"#", 8'h0a, 8'h0d: ; // comment or blank line
					default: begin
						$display("unknown command in vector file: %0s", line);
						test_errs++;
					end
				endcase
			end
			$fclose(fd);
			close_test();
		end
		$display("summary: %0d tests, %0d failed, %0d errors", n_tests, n_failed, n_errors);
		if (n_errors == 0 && n_failed == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: verification/imager_vectors.txt
# cmd and hex args: T name | W b0 b1 b2 | B count first_byte | R word | Q count first_byte
# F {pixel_avail pix_full frame_ready two_frames pat_avail mem_ready pat_low} | M word | S pat | X
T reset_state
F 03
T pixel_packing
W 5a 3c e1
W 01 80 ff
W 00 7e 10
R e13c5a
R ff8001
R 107e00
T buffer_flags
B 7 00
F 43
B 1 15
F 53
B 7 18
F 53
B 1 2d
F 5b
Q 8 00
F 53
Q 7 18
F 43
Q 1 2d
F 03
T overflow_drop
B 23 40
F 7b
Q 20 40
F 03
T pattern_backpressure
M abcd1234003f0040
M fe807f3fc03b0ff1
M 80005555aaaaffc0
F 04
S 001
S 000
S 048
S 2af
S 03f
S 300
S 1fc
S 3fa
S 3ff
S 2aa
S 155
S 200
F 03
T pattern_flush
M abcd1234003f0040
M fe807f3fc03b0ff1
M 80005555aaaaffc0
F 04
X
F 03

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

// free-running test clock and power-on reset
module tb_clock_gen #(
	parameter int HALF_NS      = 20, // 40 ns period
	parameter int RESET_CYCLES = 10
) (
	output logic CLK_HS,
	output logic arst_n
);

	initial begin
		CLK_HS = 1'b0;
		forever #(HALF_NS) CLK_HS = ~CLK_HS;
	end

	initial begin
		arst_n = 1'b0; // held from time zero
		repeat (RESET_CYCLES) @(posedge CLK_HS);
		#2;
		arst_n = 1'b1; // release away from the edge
	end

endmodule
